/* hdl/mem_stage_params.svh */
`ifndef MEM_STAGE_PARAMS_SVH
`define MEM_STAGE_PARAMS_SVH

// data path and address width
`define MS_XLEN 64

// destination register number width
`define MS_REGNO_W 5

// bytes in one memory word
`define MS_BYTES 8

`endif

/* hdl/mem_stage_pkg.sv */
`include "mem_stage_params.svh"

package mem_stage_pkg;

  typedef logic [`MS_XLEN-1:0] word_t;
  typedef logic [`MS_REGNO_W-1:0] regno_t;
  typedef logic [`MS_BYTES-1:0] byte_en_t;
  typedef logic [$clog2(`MS_BYTES)-1:0] offset_t;

  typedef enum logic [3:0] {
    op_none = 4'd0,
    op_lb   = 4'd1,
    op_lbu  = 4'd2,
    op_lh   = 4'd3,
    op_lhu  = 4'd4,
    op_lw   = 4'd5,
    op_lwu  = 4'd6,
    op_ld   = 4'd7,
    op_sb   = 4'd8,
    op_sh   = 4'd9,
    op_sw   = 4'd10,
    op_sd   = 4'd11
  } mem_op_t;

  // round the byte offset down to the access size
  function automatic offset_t align_offset(mem_op_t op, offset_t offset);
    case (op)
      op_lh, op_lhu, op_sh: return {offset[2:1], 1'b0};
      op_lw, op_lwu, op_sw: return {offset[2], 2'b00};
      op_ld, op_sd: return '0;
      default: return offset; // byte ops and non-memory
    endcase
  endfunction

endpackage

/* hdl/lane_if.sv */
`timescale 1ns/10ps

interface lane_if
  import mem_stage_pkg::*;
();

  mem_op_t op;
  offset_t offset; // low address bits
  word_t   store_value;
  word_t   rdata; // memory read data, fed from the top level

  modport ctrl (
    output op, offset, store_value, rdata
  );

  modport store (
    input op, offset, store_value
  );

  modport load (
    input op, offset, rdata
  );

endinterface

/* hdl/store_lane_packer.sv */
`timescale 1ns/10ps

`include "mem_stage_params.svh"

module store_lane_packer
  import mem_stage_pkg::*;
(
  lane_if.store lane,
  output byte_en_t byte_en,
  output word_t wdata
);

  byte_en_t size_mask; // enables at lane 0
  offset_t aligned;
  word_t keep; // byte mask spread to bits

  assign aligned = align_offset(lane.op, lane.offset);

  always_comb begin
    unique case (lane.op)
      op_sb: size_mask = byte_en_t'(8'h01);
      op_sh: size_mask = byte_en_t'(8'h03);
      op_sw: size_mask = byte_en_t'(8'h0f);
      op_sd: size_mask = byte_en_t'(8'hff);
      default: size_mask = '0; // loads and non-memory ops
    endcase
  end

  always_comb begin
    for (int i = 0; i < `MS_BYTES; i++) begin
      keep[8*i +: 8] = {8{size_mask[i]}};
    end
  end

  // move the low bytes of the value up to the selected lane
  assign byte_en = size_mask << aligned;
  assign wdata   = (lane.store_value & keep) << {aligned, 3'b000};

endmodule

/* hdl/load_lane_aligner.sv */
`timescale 1ns/10ps

module load_lane_aligner
  import mem_stage_pkg::*;
(
  lane_if.load lane,
  output word_t load_value
);

  offset_t aligned;
  word_t shifted; // selected lane moved to bit 0

  assign aligned = align_offset(lane.op, lane.offset);
  assign shifted = lane.rdata >> {aligned, 3'b000};

  always_comb begin
    unique case (lane.op)
      op_lb: begin
        load_value = word_t'($signed(shifted[7:0]));
      end
      op_lbu: begin
        load_value = word_t'(shifted[7:0]);
      end
      op_lh: begin
        load_value = word_t'($signed(shifted[15:0]));
      end
      op_lhu: begin
        load_value = word_t'(shifted[15:0]);
      end
      op_lw: begin
        load_value = word_t'($signed(shifted[31:0]));
      end
      op_lwu: begin
        load_value = word_t'(shifted[31:0]);
      end
      op_ld: begin
        load_value = shifted; // offset already forced to 0
      end
      default: begin
        load_value = '0; // stores and non-memory ops
      end
    endcase
  end

endmodule

/* hdl/mem_stage_ctrl.sv */
`timescale 1ns/10ps

`include "mem_stage_params.svh"

module mem_stage_ctrl
  import mem_stage_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_enable,
  input  logic     flush,
  input  mem_op_t  op,
  input  word_t    alu_result,
  input  word_t    rs2_value,
  input  word_t    pc_target,
  input  regno_t   rd_regno,
  input  logic     update_rd,
  input  logic     mm_load,
  input  logic     branch_taken,
  input  logic     mem_done,
  input  byte_en_t byte_en,
  input  word_t    wdata,
  input  word_t    load_value,
  lane_if.ctrl     lane,
  output logic     ready,
  output logic     mem_en,
  output logic     mem_write,
  output word_t    mem_addr,
  output word_t    mem_wdata,
  output byte_en_t mem_byte_en,
  output word_t    out_mdata,
  output word_t    out_alu_result,
  output word_t    out_rs2_value,
  output word_t    out_pc_target,
  output regno_t   out_rd_regno,
  output mem_op_t  out_op,
  output logic     out_update_rd,
  output logic     out_mm_load,
  output logic     out_branch_taken
);

  logic is_load;
  logic is_store;
  logic is_mem;
  logic accept;

  always_comb begin
    is_load  = 1'b0;
    is_store = 1'b0;
    case (op)
      op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld: is_load = 1'b1;
      op_sb, op_sh, op_sw, op_sd: is_store = 1'b1;
      default: ;
    endcase
  end

  assign is_mem = is_load | is_store;

  // held by upstream until ready, so the request stays put
  assign mem_en      = is_mem & in_enable & ~flush;
  assign mem_write   = mem_en & is_store;
  assign mem_addr    = {alu_result[`MS_XLEN-1:3], 3'b000}; // double-word aligned
  assign mem_wdata   = wdata;
  assign mem_byte_en = byte_en;

  // memory ops wait for the done pulse
  assign ready  = ~is_mem | flush | mem_done;
  assign accept = in_enable & ready;

  assign lane.op          = op;
  assign lane.offset      = alu_result[2:0];
  assign lane.store_value = rs2_value;

  always_ff @(posedge clk) begin
    if (!rst_n || (accept && flush)) begin
      out_mdata        <= '0;
      out_alu_result   <= '0;
      out_rs2_value    <= '0;
      out_pc_target    <= '0;
      out_rd_regno     <= '0;
      out_op           <= op_none;
      out_update_rd    <= 1'b0;
      out_mm_load      <= 1'b0;
      out_branch_taken <= 1'b0;
    end else if (accept) begin
      out_mdata        <= load_value; // zero unless a load
      out_alu_result   <= alu_result;
      out_rs2_value    <= rs2_value;
      out_pc_target    <= pc_target;
      out_rd_regno     <= rd_regno;
      out_op           <= op;
      out_update_rd    <= update_rd;
      out_mm_load      <= mm_load;
      out_branch_taken <= branch_taken;
    end
  end

endmodule

/* hdl/mem_stage.sv */
`timescale 1ns/10ps

module mem_stage
  import mem_stage_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_enable,
  input  logic     flush,
  input  mem_op_t  op,
  input  word_t    alu_result,
  input  word_t    rs2_value,
  input  word_t    pc_target,
  input  regno_t   rd_regno,
  input  logic     update_rd,
  input  logic     mm_load,
  input  logic     branch_taken,
  input  logic     mem_done,
  input  word_t    mem_rdata,
  output logic     ready,
  output logic     mem_en,
  output logic     mem_write,
  output word_t    mem_addr,
  output word_t    mem_wdata,
  output byte_en_t mem_byte_en,
  output word_t    out_mdata,
  output word_t    out_alu_result,
  output word_t    out_rs2_value,
  output word_t    out_pc_target,
  output regno_t   out_rd_regno,
  output mem_op_t  out_op,
  output logic     out_update_rd,
  output logic     out_mm_load,
  output logic     out_branch_taken
);

  byte_en_t byte_en;
  word_t    wdata;
  word_t    load_value;

  lane_if i_lane ();

  assign i_lane.rdata = mem_rdata; // read data straight from memory

  store_lane_packer i_packer (
    .lane    (i_lane.store),
    .byte_en (byte_en),
    .wdata   (wdata)
  );

  load_lane_aligner i_aligner (
    .lane       (i_lane.load),
    .load_value (load_value)
  );

  mem_stage_ctrl i_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_enable        (in_enable),
    .flush            (flush),
    .op               (op),
    .alu_result       (alu_result),
    .rs2_value        (rs2_value),
    .pc_target        (pc_target),
    .rd_regno         (rd_regno),
    .update_rd        (update_rd),
    .mm_load          (mm_load),
    .branch_taken     (branch_taken),
    .mem_done         (mem_done),
    .byte_en          (byte_en),
    .wdata            (wdata),
    .load_value       (load_value),
    .lane             (i_lane.ctrl),
    .ready            (ready),
    .mem_en           (mem_en),
    .mem_write        (mem_write),
    .mem_addr         (mem_addr),
    .mem_wdata        (mem_wdata),
    .mem_byte_en      (mem_byte_en),
    .out_mdata        (out_mdata),
    .out_alu_result   (out_alu_result),
    .out_rs2_value    (out_rs2_value),
    .out_pc_target    (out_pc_target),
    .out_rd_regno     (out_rd_regno),
    .out_op           (out_op),
    .out_update_rd    (out_update_rd),
    .out_mm_load      (out_mm_load),
    .out_branch_taken (out_branch_taken)
  );

endmodule

/* bench/mem_stage_assert.sv */
`timescale 1ns/10ps

module mem_stage_assert
  import mem_stage_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     flush,
  input logic     mem_en,
  input logic     mem_write,
  input logic     mem_done,
  input word_t    mem_addr,
  input byte_en_t mem_byte_en
);

  a_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !mem_en)
    else $error("memory request right after reset");

  // request held until the done pulse
  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_en && !mem_done |=> $stable(mem_addr))
    else $error("mem_addr changed during a pending access");

  a_store_lanes: assert property (@(posedge clk) disable iff (!rst_n)
    mem_write |-> mem_byte_en != '0)
    else $error("store with no byte enables");

  a_no_flush_access: assert property (@(posedge clk) flush |-> !mem_en)
    else $error("memory request during a flush");

endmodule

bind mem_stage mem_stage_assert i_assert (.*);

/* bench/tb_mem_stage.sv */
`timescale 1ns/10ps

module tb_mem_stage
  import mem_stage_pkg::*;
();

  localparam int max_ops = 400;
  localparam int timeout_cycles = max_ops * 5 + 50;
  localparam word_t addr_base = 64'h0000_0008_8000_0000;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     in_enable;
  logic     flush;
  mem_op_t  op;
  word_t    alu_result;
  word_t    rs2_value;
  word_t    pc_target;
  regno_t   rd_regno;
  logic     update_rd;
  logic     mm_load;
  logic     branch_taken;
  logic     mem_done = 1'b0;
  word_t    mem_rdata = '0;
  logic     ready;
  logic     mem_en;
  logic     mem_write;
  word_t    mem_addr;
  word_t    mem_wdata;
  byte_en_t mem_byte_en;
  word_t    out_mdata;
  word_t    out_alu_result;
  word_t    out_rs2_value;
  word_t    out_pc_target;
  regno_t   out_rd_regno;
  mem_op_t  out_op;
  logic     out_update_rd;
  logic     out_mm_load;
  logic     out_branch_taken;

  word_t mem_model [64];
  word_t shadow [64]; // what memory should hold
  logic [31:0] rng_state = 32'h8120_ce9b;
  logic mem_busy = 1'b0;
  int wait_left = 0;
  int issued_count = 0;
  int counted_at_accept = 0;
  int cycle_count = 0;
  logic checks_on = 1'b0;

  // expected registered outputs
  word_t   exp_mdata = '0;
  word_t   exp_alu_result = '0;
  word_t   exp_rs2_value = '0;
  word_t   exp_pc_target = '0;
  regno_t  exp_rd_regno = '0;
  mem_op_t exp_op = op_none;
  logic    exp_update_rd = 1'b0;
  logic    exp_mm_load = 1'b0;
  logic    exp_branch_taken = 1'b0;

  mem_op_t store_ops [4] = '{op_sb, op_sh, op_sw, op_sd};
  mem_op_t load_ops [7] = '{op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};

  mem_stage i_mem_stage (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic word_t rand_word();
    return {next_rand(), next_rand()};
  endfunction

  function automatic logic is_load_op(input mem_op_t o);
    return o inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
  endfunction

  function automatic logic is_store_op(input mem_op_t o);
    return o inside {op_sb, op_sh, op_sw, op_sd};
  endfunction

  function automatic logic is_mem_op(input mem_op_t o);
    return is_load_op(o) || is_store_op(o);
  endfunction

  function automatic int access_size(input mem_op_t o);
    case (o)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_lwu, op_sw: return 4;
      op_ld, op_sd: return 8;
      default: return 0;
    endcase
  endfunction

  // returns expected load data and writes store bytes into the shadow word
  function automatic word_t ref_access(input mem_op_t o, input offset_t offset,
                                       input word_t value, inout word_t shadow_word);
    int size;
    int base;
    word_t result;
    size = access_size(o);
    result = '0;
    if (size == 0) begin
      return result;
    end
    base = (int'(offset) / size) * size; // round down to the access size
    for (int i = 0; i < size; i++) begin
      if (is_store_op(o)) begin
        shadow_word[8*(base+i) +: 8] = value[8*i +: 8];
      end else begin
        result[8*i +: 8] = shadow_word[8*(base+i) +: 8];
      end
    end
    if (o inside {op_lb, op_lh, op_lw}) begin
      for (int j = 8 * size; j < 64; j++) begin
        result[j] = result[8*size-1];
      end
    end
    return result;
  endfunction

  function automatic byte_en_t byte_lanes(input mem_op_t o, input offset_t offset);
    int size;
    int base;
    byte_en_t lanes;
    size = access_size(o);
    lanes = '0;
    if (is_store_op(o)) begin
      base = (int'(offset) / size) * size;
      for (int i = 0; i < 8; i++) begin
        lanes[i] = (i >= base) && (i < base + size);
      end
    end
    return lanes;
  endfunction

  function automatic logic accepts();
    return in_enable && (!is_mem_op(op) || flush || mem_done);
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_now($sformatf("error at %0d ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_regno(input string name, input regno_t got, input regno_t exp);
    if (got !== exp) begin
      fail_now($sformatf("error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_op(input string name, input mem_op_t got, input mem_op_t exp);
    if (got !== exp) begin
      fail_now($sformatf("error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_byte_en(input string name, input byte_en_t got, input byte_en_t exp);
    if (got !== exp) begin
      fail_now($sformatf("error at %0d ns: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("error at %0d ns: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  // drive one instruction and hold it until the stage takes it
  task automatic run_op(input mem_op_t o, input word_t addr, input word_t value, input logic fl);
    logic [31:0] r;
    r = next_rand();
    in_enable    <= 1'b1;
    flush        <= fl;
    op           <= o;
    alu_result   <= addr;
    rs2_value    <= value;
    pc_target    <= rand_word();
    rd_regno     <= regno_t'(r);
    update_rd    <= r[8] | is_load_op(o);
    mm_load      <= is_load_op(o);
    branch_taken <= r[9] & ~is_mem_op(o);
    @(posedge clk);
    while (!accepts()) begin
      @(posedge clk);
    end
  endtask

  // memory with 0 to 3 wait cycles
  always @(posedge clk) begin
    if (mem_done) begin
      mem_done <= 1'b0;
      if (mem_write) begin
        for (int i = 0; i < 8; i++) begin
          if (mem_byte_en[i]) begin
            mem_model[mem_addr[8:3]][8*i +: 8] = mem_wdata[8*i +: 8];
          end
        end
      end
    end else if (mem_en) begin
      if (!mem_busy) begin
        mem_busy = 1'b1;
        wait_left = next_rand() % 4;
      end
      if (wait_left == 0) begin
        mem_done  <= 1'b1;
        mem_rdata <= mem_model[mem_addr[8:3]];
        mem_busy = 1'b0;
        issued_count++;
      end else begin
        wait_left--;
      end
    end
  end

  always @(posedge clk) begin
    word_t shadow_word;
    int idx;
    if (rst_n && accepts()) begin
      if (issued_count - counted_at_accept != ((is_mem_op(op) && !flush) ? 1 : 0)) begin
        fail_now("wrong number of memory accesses for one instruction");
      end
      counted_at_accept = issued_count;
      if (flush) begin
        exp_mdata = '0;
        exp_alu_result = '0;
        exp_rs2_value = '0;
        exp_pc_target = '0;
        exp_rd_regno = '0;
        exp_op = op_none;
        exp_update_rd = 1'b0;
        exp_mm_load = 1'b0;
        exp_branch_taken = 1'b0;
      end else begin
        idx = int'(alu_result[8:3]);
        shadow_word = shadow[idx];
        exp_mdata = ref_access(op, alu_result[2:0], rs2_value, shadow_word);
        shadow[idx] = shadow_word;
        exp_alu_result = alu_result;
        exp_rs2_value = rs2_value;
        exp_pc_target = pc_target;
        exp_rd_regno = rd_regno;
        exp_op = op;
        exp_update_rd = update_rd;
        exp_mm_load = mm_load;
        exp_branch_taken = branch_taken;
      end
    end
  end

  always @(negedge clk) begin
    word_t exp_wdata;
    if (checks_on) begin
      check_bit("ready", ready, !is_mem_op(op) || flush || mem_done);
      check_bit("mem_en", mem_en, in_enable && is_mem_op(op) && !flush);
      check_bit("mem_write", mem_write, in_enable && is_store_op(op) && !flush);
      if (mem_en) begin
        exp_wdata = '0;
        void'(ref_access(op, alu_result[2:0], rs2_value, exp_wdata)); // store lanes only
        check_word("mem_addr", mem_addr, {alu_result[63:3], 3'b000});
        check_byte_en("mem_byte_en", mem_byte_en, byte_lanes(op, alu_result[2:0]));
        check_word("mem_wdata", mem_wdata, exp_wdata);
      end
      check_word("out_mdata", out_mdata, exp_mdata);
      check_word("out_alu_result", out_alu_result, exp_alu_result);
      check_word("out_rs2_value", out_rs2_value, exp_rs2_value);
      check_word("out_pc_target", out_pc_target, exp_pc_target);
      check_regno("out_rd_regno", out_rd_regno, exp_rd_regno);
      check_op("out_op", out_op, exp_op);
      check_bit("out_update_rd", out_update_rd, exp_update_rd);
      check_bit("out_mm_load", out_mm_load, exp_mm_load);
      check_bit("out_branch_taken", out_branch_taken, exp_branch_taken);
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
      fail_now($sformatf("timeout: test still running after %0d cycles", timeout_cycles));
    end
  end

  initial begin
    word_t base;
    logic [31:0] r;
    mem_op_t o;
    int size;
    rst_n = 1'b0;
    in_enable = 1'b0;
    flush = 1'b0;
    op = op_none;
    alu_result = '0;
    rs2_value = '0;
    pc_target = '0;
    rd_regno = '0;
    update_rd = 1'b0;
    mm_load = 1'b0;
    branch_taken = 1'b0;
    for (int i = 0; i < 64; i++) begin
      mem_model[i] = (word_t'(i) * 64'h0101_0101_0101_0101) ^ 64'hf0e1_d2c3_b4a5_9687;
      shadow[i] = mem_model[i];
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    checks_on = 1'b1; // registered outputs must read zero from here
    @(posedge clk);

    repeat (10) run_op(op_none, rand_word(), rand_word(), 1'b0);

    for (int w = 0; w < 2; w++) begin
      base = addr_base | word_t'((w * 37 + 5) << 3);
      foreach (store_ops[s]) begin
        size = access_size(store_ops[s]);
        for (int off = 0; off < 8; off += size) begin
          run_op(store_ops[s], base | word_t'(off), rand_word(), 1'b0);
          run_op(op_ld, base, '0, 1'b0); // whole word shows the written lanes
        end
      end
      foreach (load_ops[l]) begin
        size = access_size(load_ops[l]);
        for (int off = 0; off < 8; off += size) begin
          run_op(load_ops[l], base | word_t'(off), rand_word(), 1'b0);
        end
      end
    end

    for (int k = 0; k < 4; k++) begin
      base = addr_base | word_t'((k + 20) << 3);
      o = (k % 2 == 0) ? op_sd : op_lw;
      run_op(op_ld, base, '0, 1'b0);
      run_op(o, base, rand_word(), 1'b1);
      run_op(op_ld, base, '0, 1'b0); // flushed store left memory alone
    end

    repeat (200) begin
      r = next_rand();
      o = mem_op_t'(4'(r % 32'd12));
      run_op(o, addr_base | word_t'(r[16:8]), rand_word(), r[31:28] == 4'h0);
    end

    in_enable <= 1'b0;
    flush <= 1'b0;
    repeat (2) @(posedge clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* mem_stage.f */
+incdir+hdl
hdl/mem_stage_pkg.sv
hdl/lane_if.sv
hdl/store_lane_packer.sv
hdl/load_lane_aligner.sv
hdl/mem_stage_ctrl.sv
hdl/mem_stage.sv
bench/mem_stage_assert.sv
bench/tb_mem_stage.sv

/* Makefile */
SIM := obj_dir/Vtb_mem_stage
SRCS := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(SIM): mem_stage.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_mem_stage -f mem_stage.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
